// File: logic/tcdm_tile_settings.svh
// Sizes of the tile data memory system
// Cores, banks, rows per bank and the widths derived from them

`ifndef TCDM_TILE_SETTINGS_SVH
`define TCDM_TILE_SETTINGS_SVH

// Core request ports and word-interleaved banks
`define TCDM_NUM_CORES   4
`define TCDM_NUM_BANKS   8
`define TCDM_BANK_ROWS   64

// Word and id widths
`define TCDM_DATA_W      32
`define TCDM_META_ID_W   3

// Byte address layout, offset then bank then row
`define TCDM_BYTE_OFFSET 2
`define TCDM_ADDR_W \
  (`TCDM_BYTE_OFFSET + $clog2(`TCDM_NUM_BANKS) + $clog2(`TCDM_BANK_ROWS))

`endif

// File: logic/tcdm_pkg.sv
// Shared types of the tile data memory
// Index and word types, bank request and response records

`include "tcdm_tile_settings.svh"

package tcdm_pkg;

  typedef logic [$clog2(`TCDM_NUM_CORES)-1:0] core_idx_t;
  typedef logic [$clog2(`TCDM_NUM_BANKS)-1:0] bank_idx_t;
  typedef logic [$clog2(`TCDM_BANK_ROWS)-1:0] row_t;
  typedef logic [`TCDM_ADDR_W-1:0]            tcdm_addr_t;
  typedef logic [`TCDM_DATA_W-1:0]            data_t;
  typedef logic [`TCDM_DATA_W/8-1:0]          strb_t;
  typedef logic [`TCDM_META_ID_W-1:0]         meta_id_t;

  // Request as seen by one bank
  typedef struct packed {
    row_t      row;
    logic      write;
    data_t     wdata;
    strb_t     be;
    core_idx_t ini;
    meta_id_t  id;
  } bank_req_t;

  // Read response, routed back to the core named by ini
  typedef struct packed {
    core_idx_t ini;
    meta_id_t  id;
    data_t     rdata;
  } bank_resp_t;

endpackage

// File: logic/tcdm_stream_reg.sv
// Two-entry spill register for a valid/ready stream
// Ready towards the source depends on register state only

module tcdm_stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t a_data_q;
  payload_t b_data_q;
  logic     a_full_q;
  logic     b_full_q;
  logic     a_fill;
  logic     a_drain;
  logic     b_fill;
  logic     b_drain;

  // Entry A takes new items, entry B catches one when the sink stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older item sits in B whenever B is full
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // Stalled output keeps its item
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// File: logic/tcdm_req_xbar.sv
// Request crossbar from the core ports to the banks
// Bank decode, request packing and per-bank round-robin arbitration

`include "tcdm_tile_settings.svh"

module tcdm_req_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_req_valid_i,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_CORES-1:0]   core_req_addr_i,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_req_write_i,
  input  tcdm_pkg::data_t      [`TCDM_NUM_CORES-1:0]   core_req_wdata_i,
  input  tcdm_pkg::strb_t      [`TCDM_NUM_CORES-1:0]   core_req_be_i,
  input  tcdm_pkg::meta_id_t   [`TCDM_NUM_CORES-1:0]   core_req_id_i,
  output logic                 [`TCDM_NUM_CORES-1:0]   core_req_ready_o,
  output logic                 [`TCDM_NUM_BANKS-1:0]   bank_valid_o,
  output tcdm_pkg::bank_req_t  [`TCDM_NUM_BANKS-1:0]   bank_req_o,
  input  logic                 [`TCDM_NUM_BANKS-1:0]   bank_ready_i
);

  import tcdm_pkg::*;

  localparam int unsigned BankLsb = `TCDM_BYTE_OFFSET;
  localparam int unsigned RowLsb  = BankLsb + $bits(bank_idx_t);

  bank_idx_t [`TCDM_NUM_CORES-1:0]                      tgt_bank;
  bank_req_t [`TCDM_NUM_CORES-1:0]                      core_req;
  logic      [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_CORES-1:0] bank_grant;

  for (genvar c = 0; c < `TCDM_NUM_CORES; c++) begin : gen_core_decode
    assign tgt_bank[c] = core_req_addr_i[c][BankLsb +: $bits(bank_idx_t)];
    assign core_req[c] = '{
      row:   core_req_addr_i[c][RowLsb +: $bits(row_t)],
      write: core_req_write_i[c],
      wdata: core_req_wdata_i[c],
      be:    core_req_be_i[c],
      ini:   core_idx_t'(c),
      id:    core_req_id_i[c]
    };
    // Ready only through the grant of the targeted bank
    assign core_req_ready_o[c] = bank_grant[tgt_bank[c]][c] && bank_ready_i[tgt_bank[c]];
  end

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank_arb
    logic      [`TCDM_NUM_CORES-1:0] hit;
    logic      [`TCDM_NUM_CORES-1:0] grant;
    core_idx_t                       rr_q;
    core_idx_t                       win;

    for (genvar c = 0; c < `TCDM_NUM_CORES; c++) begin : gen_hit
      assign hit[c] = core_req_valid_i[c] && (tgt_bank[c] == bank_idx_t'(b));
    end

    // First requester at or after the pointer wins
    always_comb begin
      core_idx_t idx;
      logic      found;
      grant = '0;
      win   = rr_q;
      found = 1'b0;
      for (int unsigned i = 0; i < `TCDM_NUM_CORES; i++) begin
        idx = core_idx_t'(rr_q + i);
        if (hit[idx] && !found) begin
          grant[idx] = 1'b1;
          win        = idx;
          found      = 1'b1;
        end
      end
    end

    assign bank_grant[b]   = grant;
    assign bank_valid_o[b] = |grant;
    assign bank_req_o[b]   = core_req[win];

    // Pointer moves past the winner on a transfer only
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_q <= '0;
      end else if (bank_valid_o[b] && bank_ready_i[b]) begin
        rr_q <= core_idx_t'(win + 1'b1);
      end
    end

    // One grant per bank, and at most one of its requesters sees ready
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(grant) && $onehot0(hit & core_req_ready_o));
  end

endmodule

// File: logic/tcdm_bank.sv
// Single-port SRAM bank with byte-enable writes
// Read data leaves as a held response carrying ini and id

`include "tcdm_tile_settings.svh"

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  tcdm_pkg::bank_req_t  req_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output tcdm_pkg::bank_resp_t resp_o
);

  import tcdm_pkg::*;

  data_t      mem_q [`TCDM_BANK_ROWS];
  bank_resp_t resp_q;
  logic       resp_valid_q;
  logic       req_fire;

  // Free unless a read response is waiting and not leaving
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_i.write) begin
      for (int unsigned i = 0; i < `TCDM_DATA_W / 8; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire && !req_i.write) begin
      resp_q <= '{ini: req_i.ini, id: req_i.id, rdata: mem_q[req_i.row]};
    end
  end

  // Writes produce no response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= !req_i.write;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  // A stalled response stays valid and unchanged
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// File: logic/tcdm_resp_xbar.sv
// Response crossbar from the banks back to the cores
// Per-core round-robin selection among bank responses

`include "tcdm_tile_settings.svh"

module tcdm_resp_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                 [`TCDM_NUM_BANKS-1:0]   bank_valid_i,
  input  tcdm_pkg::bank_resp_t [`TCDM_NUM_BANKS-1:0]   bank_resp_i,
  output logic                 [`TCDM_NUM_BANKS-1:0]   bank_ready_o,
  output logic                 [`TCDM_NUM_CORES-1:0]   core_resp_valid_o,
  output tcdm_pkg::meta_id_t   [`TCDM_NUM_CORES-1:0]   core_resp_id_o,
  output tcdm_pkg::data_t      [`TCDM_NUM_CORES-1:0]   core_resp_rdata_o,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_resp_ready_i
);

  import tcdm_pkg::*;

  // Bank-major view of the grants that transfer this cycle
  logic [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_CORES-1:0] bank_take;

  for (genvar c = 0; c < `TCDM_NUM_CORES; c++) begin : gen_core_arb
    logic      [`TCDM_NUM_BANKS-1:0] hit;
    logic      [`TCDM_NUM_BANKS-1:0] grant;
    bank_idx_t                       rr_q;
    bank_idx_t                       win;

    for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_hit
      assign hit[b]          = bank_valid_i[b] && (bank_resp_i[b].ini == core_idx_t'(c));
      assign bank_take[b][c] = grant[b] && core_resp_ready_i[c];
    end

    always_comb begin
      bank_idx_t idx;
      logic      found;
      grant = '0;
      win   = rr_q;
      found = 1'b0;
      for (int unsigned i = 0; i < `TCDM_NUM_BANKS; i++) begin
        idx = bank_idx_t'(rr_q + i);
        if (hit[idx] && !found) begin
          grant[idx] = 1'b1;
          win        = idx;
          found      = 1'b1;
        end
      end
    end

    assign core_resp_valid_o[c] = |grant;
    assign core_resp_id_o[c]    = bank_resp_i[win].id;
    assign core_resp_rdata_o[c] = bank_resp_i[win].rdata;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_q <= '0;
      end else if (core_resp_valid_o[c] && core_resp_ready_i[c]) begin
        rr_q <= bank_idx_t'(win + 1'b1);
      end
    end
  end

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_bank_ready
    assign bank_ready_o[b] = |bank_take[b];

    // A bank response is taken by at most one core
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(bank_take[b]));
  end

endmodule

// File: logic/tcdm_tile.sv
// Tile data memory top level
// Request crossbar, spill registers around each bank, response crossbar

`include "tcdm_tile_settings.svh"

module tcdm_tile (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_req_valid_i,
  input  tcdm_pkg::tcdm_addr_t [`TCDM_NUM_CORES-1:0]   core_req_addr_i,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_req_write_i,
  input  tcdm_pkg::data_t      [`TCDM_NUM_CORES-1:0]   core_req_wdata_i,
  input  tcdm_pkg::strb_t      [`TCDM_NUM_CORES-1:0]   core_req_be_i,
  input  tcdm_pkg::meta_id_t   [`TCDM_NUM_CORES-1:0]   core_req_id_i,
  output logic                 [`TCDM_NUM_CORES-1:0]   core_req_ready_o,
  output logic                 [`TCDM_NUM_CORES-1:0]   core_resp_valid_o,
  output tcdm_pkg::meta_id_t   [`TCDM_NUM_CORES-1:0]   core_resp_id_o,
  output tcdm_pkg::data_t      [`TCDM_NUM_CORES-1:0]   core_resp_rdata_o,
  input  logic                 [`TCDM_NUM_CORES-1:0]   core_resp_ready_i
);

  import tcdm_pkg::*;

  // Before and after the request registers
  logic       [`TCDM_NUM_BANKS-1:0] req_pre_valid;
  logic       [`TCDM_NUM_BANKS-1:0] req_pre_ready;
  bank_req_t  [`TCDM_NUM_BANKS-1:0] req_pre;
  logic       [`TCDM_NUM_BANKS-1:0] req_post_valid;
  logic       [`TCDM_NUM_BANKS-1:0] req_post_ready;
  bank_req_t  [`TCDM_NUM_BANKS-1:0] req_post;
  // Before and after the response registers
  logic       [`TCDM_NUM_BANKS-1:0] resp_pre_valid;
  logic       [`TCDM_NUM_BANKS-1:0] resp_pre_ready;
  bank_resp_t [`TCDM_NUM_BANKS-1:0] resp_pre;
  logic       [`TCDM_NUM_BANKS-1:0] resp_post_valid;
  logic       [`TCDM_NUM_BANKS-1:0] resp_post_ready;
  bank_resp_t [`TCDM_NUM_BANKS-1:0] resp_post;

  tcdm_req_xbar i_req_xbar (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .core_req_valid_i(core_req_valid_i),
    .core_req_addr_i (core_req_addr_i ),
    .core_req_write_i(core_req_write_i),
    .core_req_wdata_i(core_req_wdata_i),
    .core_req_be_i   (core_req_be_i   ),
    .core_req_id_i   (core_req_id_i   ),
    .core_req_ready_o(core_req_ready_o),
    .bank_valid_o    (req_pre_valid   ),
    .bank_req_o      (req_pre         ),
    .bank_ready_i    (req_pre_ready   )
  );

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : gen_banks
    tcdm_stream_reg #(
      .payload_t(bank_req_t)
    ) i_req_reg (
      .clk_i  (clk_i            ),
      .rst_n_i(rst_n_i          ),
      .valid_i(req_pre_valid[b] ),
      .ready_o(req_pre_ready[b] ),
      .data_i (req_pre[b]       ),
      .valid_o(req_post_valid[b]),
      .ready_i(req_post_ready[b]),
      .data_o (req_post[b]      )
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i            ),
      .rst_n_i     (rst_n_i          ),
      .req_valid_i (req_post_valid[b]),
      .req_ready_o (req_post_ready[b]),
      .req_i       (req_post[b]      ),
      .resp_valid_o(resp_pre_valid[b]),
      .resp_ready_i(resp_pre_ready[b]),
      .resp_o      (resp_pre[b]      )
    );

    tcdm_stream_reg #(
      .payload_t(bank_resp_t)
    ) i_resp_reg (
      .clk_i  (clk_i             ),
      .rst_n_i(rst_n_i           ),
      .valid_i(resp_pre_valid[b] ),
      .ready_o(resp_pre_ready[b] ),
      .data_i (resp_pre[b]       ),
      .valid_o(resp_post_valid[b]),
      .ready_i(resp_post_ready[b]),
      .data_o (resp_post[b]      )
    );
  end

  tcdm_resp_xbar i_resp_xbar (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .bank_valid_i     (resp_post_valid  ),
    .bank_resp_i      (resp_post        ),
    .bank_ready_o     (resp_post_ready  ),
    .core_resp_valid_o(core_resp_valid_o),
    .core_resp_id_o   (core_resp_id_o   ),
    .core_resp_rdata_o(core_resp_rdata_o),
    .core_resp_ready_i(core_resp_ready_i)
  );

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and synchronous active-low reset

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Released on a rising edge after the reset cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: verif/tcdm_tile_tb.sv
// Testbench for the tile data memory
// LFSR stimulus on four cores, shadow memory model, checks and watchdog

`include "tcdm_tile_settings.svh"

module tcdm_tile_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tcdm_pkg::*;

  localparam int unsigned NumCores    = `TCDM_NUM_CORES;
  localparam int unsigned NumIds      = 2 ** `TCDM_META_ID_W;
  localparam int unsigned NumWords    = `TCDM_NUM_BANKS * `TCDM_BANK_ROWS;
  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned ReqsPerCore = 400;
  localparam int unsigned WatchdogNs  = ReqsPerCore * 40 * ClkPeriod;
  localparam logic [31:0] Seed        = 32'hc44b_039d;
  localparam bank_idx_t   HotBank     = 3'd5;

  typedef logic [$clog2(NumWords)-1:0] word_t;
  typedef enum int unsigned {
    ModeWrite, ModeRead, ModeBytes, ModeMixed, ModeConflict, ModeParallel
  } mode_e;

  logic                      clk;
  logic                      rst_n;
  logic       [NumCores-1:0] core_req_valid;
  tcdm_addr_t [NumCores-1:0] core_req_addr;
  logic       [NumCores-1:0] core_req_write;
  data_t      [NumCores-1:0] core_req_wdata;
  strb_t      [NumCores-1:0] core_req_be;
  meta_id_t   [NumCores-1:0] core_req_id;
  logic       [NumCores-1:0] core_req_ready;
  logic       [NumCores-1:0] core_resp_valid;
  meta_id_t   [NumCores-1:0] core_resp_id;
  data_t      [NumCores-1:0] core_resp_rdata;
  logic       [NumCores-1:0] core_resp_ready;

  // Reference model state
  data_t               shadow [NumWords];
  data_t               exp_data [NumCores][NumIds];
  logic [NumIds-1:0]   outstanding [NumCores];
  logic [NumCores-1:0] waited [NumCores];
  logic [NumCores-1:0] req_fire;
  int unsigned         n_out;
  logic [31:0]         lfsr_q;
  string               test_name;

  tb_clock_gen #(
    .PeriodNs   (ClkPeriod),
    .ResetCycles(16)
  ) u_clock_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  tcdm_tile u_tcdm_tile (
    .clk_i            (clk            ),
    .rst_n_i          (rst_n          ),
    .core_req_valid_i (core_req_valid ),
    .core_req_addr_i  (core_req_addr  ),
    .core_req_write_i (core_req_write ),
    .core_req_wdata_i (core_req_wdata ),
    .core_req_be_i    (core_req_be    ),
    .core_req_id_i    (core_req_id    ),
    .core_req_ready_o (core_req_ready ),
    .core_resp_valid_o(core_resp_valid),
    .core_resp_id_o   (core_resp_id   ),
    .core_resp_rdata_o(core_resp_rdata),
    .core_resp_ready_i(core_resp_ready)
  );

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic mismatch_error(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, expected, actual);
    stop_on_failure();
  endtask

  task automatic protocol_error(input string msg);
    $display("%s (test %s)", msg, test_name);
    stop_on_failure();
  endtask

  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic bank_idx_t bank_of(input tcdm_addr_t addr);
    return addr[`TCDM_BYTE_OFFSET +: $bits(bank_idx_t)];
  endfunction

  // Observe both handshakes where the signals are settled
  always @(negedge clk) begin : monitor
    word_t       word;
    meta_id_t    id;
    int unsigned hits;
    if (rst_n === 1'b1) begin
      req_fire = core_req_valid & core_req_ready;
      for (int unsigned c = 0; c < NumCores; c++) begin
        if (core_resp_valid[c] && core_resp_ready[c]) begin
          id = core_resp_id[c];
          assert (outstanding[c][id]) else
            protocol_error($sformatf("Core %0d got id %0d with no read outstanding", c, id));
          assert (core_resp_rdata[c] === exp_data[c][id]) else
            mismatch_error($sformatf("core %0d id %0d rdata", c, id), exp_data[c][id],
                           core_resp_rdata[c]);
          outstanding[c][id] = 1'b0;
          n_out--;
        end
        if (req_fire[c]) begin
          word = word_t'(core_req_addr[c] >> `TCDM_BYTE_OFFSET);
          hits = 0;
          for (int unsigned o = 0; o < NumCores; o++) begin
            if (req_fire[o] && bank_of(core_req_addr[o]) == bank_of(core_req_addr[c])) begin
              hits++;
            end
            // Someone still waiting on this bank
            if (o != c && core_req_valid[o] && !req_fire[o] &&
                bank_of(core_req_addr[o]) == bank_of(core_req_addr[c])) begin
              assert (!waited[o][c]) else
                protocol_error($sformatf("Core %0d accepted twice while core %0d waited", c, o));
              waited[o][c] = 1'b1;
            end
          end
          assert (hits == 1) else
            mismatch_error($sformatf("accepts in bank %0d", bank_of(core_req_addr[c])), 1, hits);
          waited[c] = '0;
          if (core_req_write[c]) begin
            for (int unsigned i = 0; i < `TCDM_DATA_W / 8; i++) begin
              if (core_req_be[c][i]) begin
                shadow[word][8*i +: 8] = core_req_wdata[c][8*i +: 8];
              end
            end
          end else begin
            exp_data[c][core_req_id[c]]    = shadow[word];
            outstanding[c][core_req_id[c]] = 1'b1;
            n_out++;
          end
        end
      end
    end
  end

  task automatic drive_core(input int unsigned c, input mode_e mode, input int unsigned k,
                            output logic sent);
    word_t    word;
    logic     wr;
    strb_t    be;
    meta_id_t id;
    logic     id_free;
    id      = meta_id_t'(rand_bits(`TCDM_META_ID_W));
    id_free = 1'b0;
    // Reads take the lowest id not in flight
    for (int unsigned i = 0; i < NumIds; i++) begin
      if (!outstanding[c][i] && !id_free) begin
        id      = meta_id_t'(i);
        id_free = 1'b1;
      end
    end
    be = '1;
    wr = 1'b0;
    case (mode)
      ModeWrite: begin
        word = word_t'(k * NumCores + c);
        wr   = 1'b1;
      end
      ModeRead: word = word_t'(k * NumCores + c);
      ModeBytes: begin
        word = word_t'(rand_bits(5));
        wr   = 1'(rand_bits(1));
        be   = strb_t'(rand_bits($bits(strb_t)));
      end
      ModeMixed: begin
        word = word_t'(rand_bits($bits(word_t)));
        wr   = 1'(rand_bits(1));
      end
      ModeConflict: begin
        word = {row_t'(rand_bits($bits(row_t))), HotBank};
        wr   = 1'(rand_bits(1));
      end
      default: word = {row_t'(rand_bits($bits(row_t))), bank_idx_t'(2 * c)};
    endcase
    sent = wr || id_free;
    core_req_valid[c] <= sent;
    core_req_addr[c]  <= tcdm_addr_t'(word) << `TCDM_BYTE_OFFSET;
    core_req_write[c] <= wr;
    core_req_wdata[c] <= data_t'(rand_bits(`TCDM_DATA_W));
    core_req_be[c]    <= be;
    core_req_id[c]    <= id;
  endtask

  task automatic drain_idle();
    core_req_valid  <= '0;
    core_resp_ready <= '1;
    while (n_out != 0) @(posedge clk);
    // Writes have no response, let the last ones reach their banks
    repeat (4) @(posedge clk);
  endtask

  task automatic run_traffic(input mode_e mode, input int unsigned n);
    int unsigned issued [NumCores];
    logic        busy;
    logic        sent;
    foreach (issued[c]) issued[c] = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int unsigned c = 0; c < NumCores; c++) begin
        core_resp_ready[c] <= (mode == ModeMixed) ? 1'(rand_bits(1)) : 1'b1;
        if (core_req_valid[c] && !req_fire[c]) begin
          busy = 1'b1;
        end else if (issued[c] < n) begin
          drive_core(c, mode, issued[c], sent);
          if (sent) begin
            issued[c]++;
          end
          busy = 1'b1;
        end else begin
          core_req_valid[c] <= 1'b0;
        end
      end
    end
    drain_idle();
  endtask

  initial begin
    #(WatchdogNs);
    protocol_error("Watchdog expired before all tests finished");
  end

  initial begin
    logic sent;
    lfsr_q          = Seed;
    n_out           = 0;
    req_fire        = '0;
    core_req_valid  = '0;
    core_req_addr   = '0;
    core_req_write  = '0;
    core_req_wdata  = '0;
    core_req_be     = '0;
    core_req_id     = '0;
    core_resp_ready = '1;
    foreach (outstanding[c]) outstanding[c] = '0;
    foreach (waited[c]) waited[c] = '0;

    test_name = "reset";
    while (rst_n !== 1'b1) @(posedge clk);
    @(negedge clk);
    assert (core_resp_valid == '0) else
      mismatch_error("core_resp_valid_o", 0, 32'(core_resp_valid));
    @(posedge clk);
    drive_core(0, ModeWrite, 0, sent);
    @(negedge clk);
    assert (core_req_ready[0]) else
      mismatch_error("core 0 ready", 1, 32'(core_req_ready[0]));
    @(posedge clk);
    drain_idle();

    test_name = "fill_and_read";
    run_traffic(ModeWrite, NumWords / NumCores);
    run_traffic(ModeRead, NumWords / NumCores);

    test_name = "byte_enables";
    run_traffic(ModeBytes, 32);

    test_name = "back_pressure";
    run_traffic(ModeMixed, 64);

    test_name = "bank_conflict";
    run_traffic(ModeConflict, 16);

    test_name = "parallel_banks";
    @(posedge clk);
    for (int unsigned c = 0; c < NumCores; c++) begin
      drive_core(c, ModeParallel, 0, sent);
    end
    @(negedge clk);
    assert (core_req_ready == '1) else
      mismatch_error("core_req_ready_o", 32'({NumCores{1'b1}}), 32'(core_req_ready));
    @(posedge clk);
    drain_idle();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tcdm_tile.f
+incdir+logic
logic/tcdm_pkg.sv
logic/tcdm_stream_reg.sv
logic/tcdm_req_xbar.sv
logic/tcdm_bank.sv
logic/tcdm_resp_xbar.sv
logic/tcdm_tile.sv
verif/tb_clock_gen.sv
verif/tcdm_tile_tb.sv

// File: Makefile
# Verilator build and run of the tile data memory testbench

SIM  := obj_dir/Vtcdm_tile_tb
SRCS := $(wildcard logic/*.sv logic/*.svh verif/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): tcdm_tile.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps \
		--top-module tcdm_tile_tb -f tcdm_tile.f

# Pass or fail is decided by the log
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
